// ==== logic/video_pkg.sv ====
// Tile video subsystem shared definitions
// Widths with a meaning, CPU register map and scroll fetch states

`default_nettype none

package video_pkg;

    // Raster coordinate, hdump or vdump
    typedef logic [8:0]  pos_t;
    typedef logic [9:0]  scroll_t;
    typedef logic [15:0] cpu_word_t;
    typedef logic [16:0] vram_addr_t;
    typedef logic [19:0] rom_addr_t;
    // Eight 4-bit pixels, leftmost in the top nibble
    typedef logic [31:0] rom_row_t;
    // Palette bank bit over a 4-bit colour
    typedef logic [4:0]  pxl_t;

    // Register indexes on addr
    localparam logic [4:0] REG_HPOS  = 5'd0;
    localparam logic [4:0] REG_VPOS  = 5'd1;
    localparam logic [4:0] REG_VBASE = 5'd2;
    localparam logic [4:0] REG_CTRL  = 5'd3;

    typedef enum logic [1:0] {
        IDLE,
        MAP_REQ,
        ROM_REQ,
        UNPACK
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/video_timing.sv ====
// Video timing generator
// Raster counters, blanking and sync levels, and a pulse at the end of active video

`timescale 1ns/1ns
`default_nettype none

module video_timing import video_pkg::*; #(
    parameter int H_ACTIVE = 320,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  pxl_cen,
    output pos_t hdump,
    output pos_t vdump,
    output pos_t vrender,
    output logic HB,
    output logic VB,
    output logic HS,
    output logic VS,
    output logic line_start
);

    localparam pos_t H_END  = pos_t'(H_ACTIVE - 1);
    localparam pos_t H_LAST = pos_t'(H_TOTAL - 1);
    localparam pos_t V_LAST = pos_t'(V_TOTAL - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            hdump <= (hdump == H_LAST) ? '0 : hdump + 1'b1;
            // Line number moves on as horizontal blanking begins
            if (hdump == H_END) begin
                vdump <= (vdump == V_LAST) ? '0 : vdump + 1'b1;
            end
        end
    end

    // High while hdump sits at H_ACTIVE, so vrender already points at the next line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_start <= 1'b0;
        end else begin
            line_start <= pxl_cen && (hdump == H_END);
        end
    end

    assign vrender = (vdump == V_LAST) ? '0 : vdump + 1'b1;

    assign HB = hdump >= pos_t'(H_ACTIVE);
    assign VB = vdump >= pos_t'(V_ACTIVE);

    // Sync pulses sit inside the blanking intervals
    assign HS = (hdump >= pos_t'(H_ACTIVE + 4)) && (hdump < pos_t'(H_ACTIVE + 8));
    assign VS = (vdump >= pos_t'(V_ACTIVE + 2)) && (vdump < pos_t'(V_ACTIVE + 4));

endmodule

`default_nettype wire

// ==== logic/video_regs.sv ====
// Video control registers
// CPU-written scroll position, VRAM base and control word, with byte lanes and readback

`timescale 1ns/1ns
`default_nettype none

module video_regs import video_pkg::*; (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             ppu_rstn,
    input  wire             ppu1_cs,
    input  wire logic [4:0] addr,
    input  wire logic [1:0] dsn,
    input  wire cpu_word_t  cpu_dout,
    output cpu_word_t       mmr_dout,
    output scroll_t         hpos,
    output scroll_t         vpos,
    output logic [4:0]      vram_base,
    output logic            backdrop_en
);

    cpu_word_t hpos_r, vpos_r, vbase_r, ctrl_r;

    // dsn is active low, bit 1 for the upper byte
    function automatic cpu_word_t lane_merge(cpu_word_t old_val, cpu_word_t new_val,
                                             logic [1:0] lanes);
        cpu_word_t res;
        res = old_val;
        if (!lanes[0]) res[7:0]  = new_val[7:0];
        if (!lanes[1]) res[15:8] = new_val[15:8];
        return res;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hpos_r  <= '0;
            vpos_r  <= '0;
            vbase_r <= '0;
            ctrl_r  <= '0;
        end else if (!ppu_rstn) begin
            hpos_r  <= '0;
            vpos_r  <= '0;
            vbase_r <= '0;
            ctrl_r  <= '0;
        end else if (ppu1_cs) begin
            if (addr == REG_HPOS)  hpos_r  <= lane_merge(hpos_r, cpu_dout, dsn);
            if (addr == REG_VPOS)  vpos_r  <= lane_merge(vpos_r, cpu_dout, dsn);
            if (addr == REG_VBASE) vbase_r <= lane_merge(vbase_r, cpu_dout, dsn);
            if (addr == REG_CTRL)  ctrl_r  <= lane_merge(ctrl_r, cpu_dout, dsn);
        end
    end

    always_comb begin
        mmr_dout = '0;
        if (ppu1_cs) begin
            case (addr)
                REG_HPOS:  mmr_dout = hpos_r;
                REG_VPOS:  mmr_dout = vpos_r;
                REG_VBASE: mmr_dout = vbase_r;
                REG_CTRL:  mmr_dout = ctrl_r;
                default:   mmr_dout = '0;
            endcase
        end
    end

    assign hpos        = hpos_r[9:0];
    assign vpos        = vpos_r[9:0];
    assign vram_base   = vbase_r[4:0];
    assign backdrop_en = ctrl_r[0];

endmodule

`default_nettype wire

// ==== logic/scroll_layer.sv ====
// 8x8 tile scroll layer
// Fetches map words and tile rows for the next line into a double line buffer,
// then plays the other buffer out with the fine horizontal scroll applied

`timescale 1ns/1ns
`default_nettype none

module scroll_layer import video_pkg::*; #(
    parameter int H_ACTIVE = 320
) (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             pxl_cen,
    input  wire             line_start,
    input  wire             layer_en,
    input  wire pos_t       hdump,
    input  wire pos_t       vrender,
    input  wire scroll_t    hpos,
    input  wire scroll_t    vpos,
    input  wire logic [4:0] vram_base,
    output vram_addr_t      vram_addr,
    input  wire cpu_word_t  vram_data,
    input  wire             vram_ok,
    output logic            vram_cs,
    output rom_addr_t       rom_addr,
    input  wire rom_row_t   rom_data,
    input  wire             rom_ok,
    output logic            rom_cs,
    output pxl_t            pxl
);

    // One extra tile covers the fine scroll
    localparam int TILES = H_ACTIVE / 8 + 1;
    localparam int PW    = $clog2(TILES * 8);
    localparam int CW    = $clog2(TILES);

    fetch_state_t  state;
    logic [CW-1:0] tile_cnt;
    logic [8:0]    row, next_row;
    logic [5:0]    col;
    logic [10:0]   code;
    logic          pal_bank;
    rom_row_t      row_data;
    logic          fill_bank;
    logic          cen_d;
    logic [PW-1:0] wr_base, rd_pos;
    pxl_t          line_buf [2**(PW+1)];

    assign next_row  = vrender + vpos[8:0];
    assign vram_addr = {vram_base, row[8:3], col};
    assign rom_addr  = rom_addr_t'({code, row[2:0]});
    assign wr_base   = PW'({tile_cnt, 3'b000});
    assign rd_pos    = PW'(hdump) + PW'(hpos[2:0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            tile_cnt  <= '0;
            row       <= '0;
            col       <= '0;
            fill_bank <= 1'b0;
            vram_cs   <= 1'b0;
            rom_cs    <= 1'b0;
        end else begin
            if (line_start) fill_bank <= ~fill_bank;
            case (state)
                IDLE: begin
                    if (line_start && layer_en) begin
                        row      <= next_row;
                        col      <= hpos[8:3];
                        tile_cnt <= '0;
                        vram_cs  <= 1'b1;
                        state    <= MAP_REQ;
                    end
                end
                MAP_REQ: begin
                    if (vram_ok) begin
                        vram_cs <= 1'b0;
                        rom_cs  <= 1'b1;
                        state   <= ROM_REQ;
                    end
                end
                ROM_REQ: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= UNPACK;
                    end
                end
                UNPACK: begin
                    tile_cnt <= tile_cnt + 1'b1;
                    col      <= col + 1'b1;
                    if (tile_cnt == CW'(TILES - 1)) begin
                        state <= IDLE;
                    end else begin
                        vram_cs <= 1'b1;
                        state   <= MAP_REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Tile data capture and unpacking, eight pixels per write
    always_ff @(posedge clk) begin
        if (state == MAP_REQ && vram_ok) begin
            code     <= vram_data[10:0];
            pal_bank <= vram_data[15];
        end
        if (state == ROM_REQ && rom_ok) row_data <= rom_data;
        if (state == UNPACK) begin
            for (int i = 0; i < 8; i++) begin
                line_buf[{fill_bank, wr_base + PW'(i)}] <= {pal_bank, row_data[31-4*i -: 4]};
            end
        end
    end

    // Read once per pixel, right after hdump moves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_d <= 1'b0;
            pxl   <= '0;
        end else begin
            cen_d <= pxl_cen;
            if (cen_d) pxl <= layer_en ? line_buf[{~fill_bank, rd_pos}] : '0;
        end
    end

    a_vram_hold: assert property (@(posedge clk) disable iff (!arst_n)
        vram_cs && !vram_ok |=> vram_cs);
    a_rom_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rom_cs && !rom_ok |=> rom_cs);
    // Whole line must be in the buffer before the banks swap
    a_fetch_done: assert property (@(posedge clk) disable iff (!arst_n)
        line_start |-> state == IDLE);

endmodule

`default_nettype wire

// ==== logic/color_mix.sv ====
// Colour mixer
// 32-entry 4:4:4 palette, backdrop selection and 8-bit RGB with matching blanking

`timescale 1ns/1ns
`default_nettype none

module color_mix import video_pkg::*; (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             pxl_cen,
    input  wire             ppu2_cs,
    input  wire logic [4:0] addr,
    input  wire logic [1:0] dsn,
    input  wire cpu_word_t  cpu_dout,
    input  wire pxl_t       pxl,
    input  wire             backdrop_en,
    input  wire             HB,
    input  wire             VB,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue,
    output logic            LHBL_dly,
    output logic            LVBL_dly
);

    logic [11:0] pal [32];
    logic [11:0] pal_rgb;
    logic [4:0]  pal_idx;
    logic        hb_d, vb_d;

    // Transparent colour falls through to the backdrop entry
    assign pal_idx = (backdrop_en || pxl[3:0] == 4'd0) ? 5'd0 : pxl;

    always_ff @(posedge clk) begin
        if (ppu2_cs) begin
            if (!dsn[0]) pal[addr][7:0]  <= cpu_dout[7:0];
            if (!dsn[1]) pal[addr][11:8] <= cpu_dout[11:8];
        end
        if (pxl_cen) pal_rgb <= pal[pal_idx];
    end

    // Second stage expands nibbles, blanking follows the same two enables
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hb_d     <= 1'b1;
            vb_d     <= 1'b1;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            hb_d     <= HB;
            vb_d     <= VB;
            LHBL_dly <= ~hb_d;
            LVBL_dly <= ~vb_d;
            if (hb_d || vb_d) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= {2{pal_rgb[11:8]}};
                green <= {2{pal_rgb[7:4]}};
                blue  <= {2{pal_rgb[3:0]}};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_core.sv ====
// Tile video subsystem top level
// Timing generator, control registers, one scroll layer and the colour mixer

`timescale 1ns/1ns
`default_nettype none

module video_core import video_pkg::*; #(
    parameter int H_ACTIVE = 320,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  wire             clk,
    input  wire             arst_n,
    input  wire             pxl_cen,
    input  wire             ppu_rstn,
    input  wire             ppu1_cs,
    input  wire             ppu2_cs,
    input  wire logic [4:0] addr,
    input  wire logic [1:0] dsn,
    input  wire cpu_word_t  cpu_dout,
    input  wire logic [3:0] gfx_en,
    output cpu_word_t       mmr_dout,
    output vram_addr_t      vram_addr,
    input  wire cpu_word_t  vram_data,
    input  wire             vram_ok,
    output logic            vram_cs,
    output rom_addr_t       rom_addr,
    input  wire rom_row_t   rom_data,
    input  wire             rom_ok,
    output logic            rom_cs,
    output pos_t            hdump,
    output pos_t            vdump,
    output logic            HS,
    output logic            VS,
    output logic            HB,
    output logic            VB,
    output logic            LHBL_dly,
    output logic            LVBL_dly,
    output logic [7:0]      red,
    output logic [7:0]      green,
    output logic [7:0]      blue
);

    pos_t       vrender;
    logic       line_start;
    scroll_t    hpos, vpos;
    logic [4:0] vram_base;
    logic       backdrop_en;
    pxl_t       scr_pxl;

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_timing (
        .clk, .arst_n, .pxl_cen,
        .hdump, .vdump, .vrender,
        .HB, .VB, .HS, .VS, .line_start
    );

    video_regs u_regs (
        .clk, .arst_n, .ppu_rstn, .ppu1_cs, .addr, .dsn, .cpu_dout,
        .mmr_dout, .hpos, .vpos, .vram_base, .backdrop_en
    );

    scroll_layer #(
        .H_ACTIVE ( H_ACTIVE )
    ) u_scroll (
        .clk, .arst_n, .pxl_cen, .line_start,
        .layer_en ( gfx_en[0] ),
        .hdump, .vrender, .hpos, .vpos, .vram_base,
        .vram_addr, .vram_data, .vram_ok, .vram_cs,
        .rom_addr, .rom_data, .rom_ok, .rom_cs,
        .pxl      ( scr_pxl   )
    );

    color_mix u_colmix (
        .clk, .arst_n, .pxl_cen, .ppu2_cs, .addr, .dsn, .cpu_dout,
        .pxl      ( scr_pxl   ),
        .backdrop_en, .HB, .VB,
        .red, .green, .blue, .LHBL_dly, .LVBL_dly
    );

endmodule

`default_nettype wire

// ==== sim/video_checker.sv ====
// Output checker for the tile video subsystem
// Tracks the raster from the delayed blanking signals, compares expected pixels
// and register reads, and checks line, frame and sync lengths

`timescale 1ns/1ns
`default_nettype none

module video_checker import video_pkg::*; #(
    parameter int H_ACTIVE = 32,
    parameter int V_ACTIVE = 16,
    parameter int H_TOTAL  = 48
) (
    input  wire              clk,
    input  wire              arst_n,
    input  wire              pxl_cen,
    input  wire              lhbl,
    input  wire              lvbl,
    input  wire              hs,
    input  wire              vs,
    input  wire              hb,
    input  wire              vb,
    input  wire pos_t        hdump,
    input  wire pos_t        vdump,
    input  wire logic [7:0]  red,
    input  wire logic [7:0]  green,
    input  wire logic [7:0]  blue,
    input  wire cpu_word_t   mmr_dout,
    input  wire              add_exp,
    input  wire logic [8:0]  exp_x,
    input  wire logic [8:0]  exp_y,
    input  wire logic [23:0] exp_rgb,
    input  wire              rd_chk,
    input  wire cpu_word_t   rd_exp,
    output int               pix_errs,
    output int               rd_errs,
    output int               raster_errs,
    output int               pix_checked
);

    localparam int NPIX = H_ACTIVE * V_ACTIVE;

    logic [23:0] want [NPIX];
    bit          want_on [NPIX];
    logic        lhbl_q = 1'b0;
    logic        lvbl_q = 1'b0;
    logic        hs_q = 1'b0;
    logic        vs_q = 1'b0;
    // Raster position and blanking as seen one and two pixel enables back
    pos_t        hd_q1 = '0;
    pos_t        hd_q2 = '0;
    pos_t        vd_q1 = '0;
    pos_t        vd_q2 = '0;
    logic        hb_q1 = 1'b0;
    logic        hb_q2 = 1'b0;
    logic        vb_q1 = 1'b0;
    logic        vb_q2 = 1'b0;
    int          n_samp = 0;
    int          x = 0;
    int          y = -1;
    int          run_len = 0;
    int          hs_len = 0;
    int          vs_len = 0;
    int          n_pix = 0;
    int          n_rd = 0;
    int          n_raster = 0;
    int          n_checked = 0;

    assign pix_errs    = n_pix;
    assign rd_errs     = n_rd;
    assign raster_errs = n_raster;
    assign pix_checked = n_checked;

    always @(posedge clk) begin
        if (add_exp && exp_x < H_ACTIVE && exp_y < V_ACTIVE) begin
            want[exp_y * H_ACTIVE + exp_x]    = exp_rgb;
            want_on[exp_y * H_ACTIVE + exp_x] = 1'b1;
        end
        if (rd_chk && mmr_dout !== rd_exp) begin
            n_rd++;
            $display("[FAIL] %0t ns: register read %04h, expected %04h",
                     $time, mmr_dout, rd_exp);
        end
        if (pxl_cen) begin
            // Delayed blanking trails HB and VB by two pixel enables
            if (n_samp >= 2 && (lhbl !== !hb_q2 || lvbl !== !vb_q2)) begin
                n_raster++;
                $display("[FAIL] %0t ns: delayed blanking %b%b, expected %b%b",
                         $time, lhbl, lvbl, !hb_q2, !vb_q2);
            end
            // Vertical blanking ends before the first line begins
            if (lvbl && !lvbl_q) y = -1;
            if (lhbl && !lhbl_q) begin
                x = 0;
                run_len = 0;
                if (lvbl) y = y + 1;
            end else if (lhbl) begin
                x = x + 1;
            end
            if (lhbl) run_len++;
            if (!lhbl && lhbl_q && run_len != H_ACTIVE) begin
                n_raster++;
                $display("[FAIL] %0t ns: line had %0d active pixels, expected %0d",
                         $time, run_len, H_ACTIVE);
            end
            if (!lvbl && lvbl_q) begin
                if (y + 1 != V_ACTIVE) begin
                    n_raster++;
                    $display("[FAIL] %0t ns: frame had %0d lines, expected %0d",
                             $time, y + 1, V_ACTIVE);
                end
                for (int i = 0; i < NPIX; i++) want_on[i] = 1'b0;
            end
            if (!(lhbl && lvbl)) begin
                if ({red, green, blue} !== 24'h0) begin
                    n_raster++;
                    $display("[FAIL] %0t ns: RGB %02h%02h%02h during blanking",
                             $time, red, green, blue);
                end
            end else if (y >= 0 && y < V_ACTIVE && x < H_ACTIVE) begin
                // Output pixel (x,y) was presented as hdump x on line vdump y
                if (n_samp >= 2 && (hd_q2 !== pos_t'(x) || vd_q2 !== pos_t'(y))) begin
                    n_raster++;
                    $display("[FAIL] %0t ns: pixel (%0d,%0d) came from hdump %0d, vdump %0d",
                             $time, x, y, hd_q2, vd_q2);
                end
                if (want_on[y * H_ACTIVE + x]) begin
                    n_checked++;
                    if ({red, green, blue} !== want[y * H_ACTIVE + x]) begin
                        n_pix++;
                        $display("[FAIL] %0t ns: pixel (%0d,%0d) is %02h%02h%02h, expected %06h",
                                 $time, x, y, red, green, blue, want[y * H_ACTIVE + x]);
                    end
                end
            end
            // Sync widths in pixels
            if (hs) hs_len++;
            if (!hs && hs_q) begin
                if (hs_len != 4) begin
                    n_raster++;
                    $display("[FAIL] %0t ns: HS lasted %0d pixels, expected 4", $time, hs_len);
                end
                hs_len = 0;
            end
            if (vs) vs_len++;
            if (!vs && vs_q) begin
                if (vs_len != 2 * H_TOTAL) begin
                    n_raster++;
                    $display("[FAIL] %0t ns: VS lasted %0d pixels, expected %0d",
                             $time, vs_len, 2 * H_TOTAL);
                end
                vs_len = 0;
            end
            lhbl_q = lhbl;
            lvbl_q = lvbl;
            hs_q   = hs;
            vs_q   = vs;
            hd_q2  = hd_q1;
            hd_q1  = hdump;
            vd_q2  = vd_q1;
            vd_q1  = vdump;
            hb_q2  = hb_q1;
            hb_q1  = hb;
            vb_q2  = vb_q1;
            vb_q1  = vb;
            n_samp = arst_n ? n_samp + 1 : 0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_video.sv ====
// Testbench for the tile video subsystem
// Runs a small frame, models VRAM and graphics ROM with random latency,
// and plays the command file that holds CPU accesses and expected results

`timescale 1ns/1ns
`default_nettype none

module tb_video import video_pkg::*; ;

    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 48;
    localparam int V_ACTIVE = 16;
    localparam int V_TOTAL  = 20;

    logic       clk = 1'b0;
    logic       pxl_cen = 1'b0;
    logic       arst_n, ppu_rstn, ppu1_cs, ppu2_cs;
    logic [4:0] addr;
    logic [1:0] dsn;
    cpu_word_t  cpu_dout, mmr_dout, vram_data;
    logic [3:0] gfx_en;
    vram_addr_t vram_addr;
    rom_addr_t  rom_addr;
    rom_row_t   rom_data;
    logic       vram_ok, vram_cs, rom_ok, rom_cs;
    pos_t       hdump, vdump;
    logic       hs, vs, hb, vb, lhbl_dly, lvbl_dly;
    logic [7:0] red, green, blue;

    // Expectations handed to the checker
    logic        add_exp, rd_chk;
    logic [8:0]  exp_x, exp_y;
    logic [23:0] exp_rgb;
    cpu_word_t   rd_exp;
    int          pix_errs, rd_errs, raster_errs, pix_checked;

    integer      seed = 32'hcbb1f804;
    logic [7:0]  cmd_q [$];
    logic [23:0] arg_a [$];
    logic [23:0] arg_b [$];
    logic [23:0] arg_c [$];
    int          n_frames = 0;
    int          n_pix_exp = 0;
    int          n_bad = 0;
    logic        loaded = 1'b0;
    int          vram_wait = 0;
    int          rom_wait = 0;

    always #10 clk = ~clk;

    always @(negedge clk) pxl_cen <= ~pxl_cen;

    video_core #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_dut (
        .clk, .arst_n, .pxl_cen, .ppu_rstn, .ppu1_cs, .ppu2_cs,
        .addr, .dsn, .cpu_dout, .gfx_en, .mmr_dout,
        .vram_addr, .vram_data, .vram_ok, .vram_cs,
        .rom_addr, .rom_data, .rom_ok, .rom_cs,
        .hdump, .vdump,
        .HS       ( hs       ),
        .VS       ( vs       ),
        .HB       ( hb       ),
        .VB       ( vb       ),
        .LHBL_dly ( lhbl_dly ),
        .LVBL_dly ( lvbl_dly ),
        .red, .green, .blue
    );

    video_checker #(
        .H_ACTIVE ( H_ACTIVE ),
        .V_ACTIVE ( V_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  )
    ) u_checker (
        .clk, .arst_n, .pxl_cen,
        .lhbl     ( lhbl_dly ),
        .lvbl     ( lvbl_dly ),
        .hs, .vs, .hb, .vb, .hdump, .vdump,
        .red, .green, .blue, .mmr_dout,
        .add_exp, .exp_x, .exp_y, .exp_rgb, .rd_chk, .rd_exp,
        .pix_errs, .rd_errs, .raster_errs, .pix_checked
    );

    function automatic int draw_latency();
        return 1 + ({$random(seed)} % 4);
    endfunction

    // Map word: bank bit from the lowest address bit, code from the low 11 bits
    function automatic cpu_word_t vram_word(input vram_addr_t a);
        return {a[0], 4'b0000, a[10:0]};
    endfunction

    // Pixel i of row r is (r + i) mod 16, leftmost pixel in the top nibble
    function automatic rom_row_t rom_row(input rom_addr_t r);
        rom_row_t v;
        for (int i = 0; i < 8; i++) begin
            v[31-4*i -: 4] = r[3:0] + 4'(i);
        end
        return v;
    endfunction

    // VRAM model
    always @(negedge clk) begin
        vram_ok <= 1'b0;
        if (vram_cs && !vram_ok) begin
            if (vram_wait == 0) vram_wait = draw_latency();
            vram_wait = vram_wait - 1;
            if (vram_wait == 0) begin
                vram_ok   <= 1'b1;
                vram_data <= vram_word(vram_addr);
            end
        end
    end

    // Graphics ROM model
    always @(negedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && !rom_ok) begin
            if (rom_wait == 0) rom_wait = draw_latency();
            rom_wait = rom_wait - 1;
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_row(rom_addr);
            end
        end
    end

    task automatic load_stimulus(output int ok);
        int          fd;
        int          n;
        logic [63:0] tok;
        logic [639:0] skip;
        logic [23:0] a, b, c;
        ok = 0;
        fd = $fopen("sim/video_stimulus.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok == "#") begin
                    n = $fgets(skip, fd);
                end else if (n == 1) begin
                    a = '0;
                    b = '0;
                    c = '0;
                    case (tok)
                        "W", "X": n = $fscanf(fd, "%h %h %h", a, b, c);
                        "P", "R": n = $fscanf(fd, "%h %h", a, b);
                        "G":      n = $fscanf(fd, "%h", a);
                        "C", "F": n = 0;
                        default: begin
                            $display("Unknown command in the stimulus file");
                            n_bad++;
                        end
                    endcase
                    if (tok == "F") n_frames++;
                    if (tok == "X") n_pix_exp++;
                    cmd_q.push_back(tok[7:0]);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                    arg_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic cpu_access(input logic reg_sel, input logic [4:0] a,
                              input logic [1:0] lanes, input cpu_word_t d);
        @(negedge clk);
        ppu1_cs  = reg_sel;
        ppu2_cs  = !reg_sel;
        addr     = a;
        dsn      = lanes;
        cpu_dout = d;
        @(negedge clk);
        ppu1_cs = 1'b0;
        ppu2_cs = 1'b0;
        dsn     = 2'b11;
    endtask

    // No byte lane is enabled, so the access only reads
    task automatic check_readback(input logic [4:0] a, input cpu_word_t expected);
        @(negedge clk);
        ppu1_cs = 1'b1;
        addr    = a;
        dsn     = 2'b11;
        rd_exp  = expected;
        rd_chk  = 1'b1;
        @(negedge clk);
        ppu1_cs = 1'b0;
        rd_chk  = 1'b0;
    endtask

    task automatic pulse_ppu_reset();
        @(negedge clk);
        ppu_rstn = 1'b0;
        @(negedge clk);
        ppu_rstn = 1'b1;
    endtask

    // Frames begin where the delayed vertical blanking starts
    task automatic wait_frame();
        @(negedge lvbl_dly);
        repeat (4) @(negedge clk);
    endtask

    task automatic expect_pixel(input logic [8:0] x, input logic [8:0] y,
                                input logic [23:0] rgb);
        @(negedge clk);
        exp_x   = x;
        exp_y   = y;
        exp_rgb = rgb;
        add_exp = 1'b1;
        @(negedge clk);
        add_exp = 1'b0;
    endtask

    task automatic run_commands();
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "W": cpu_access(1'b1, arg_a[i][4:0], arg_b[i][1:0], arg_c[i][15:0]);
                "P": cpu_access(1'b0, arg_a[i][4:0], 2'b00, arg_b[i][15:0]);
                "R": check_readback(arg_a[i][4:0], arg_b[i][15:0]);
                "C": pulse_ppu_reset();
                "G": begin
                    @(negedge clk);
                    gfx_en = arg_a[i][3:0];
                end
                "F": wait_frame();
                "X": expect_pixel(arg_a[i][8:0], arg_b[i][8:0], arg_c[i]);
                default: ;
            endcase
        end
    endtask

    initial begin
        int ok;
        int total;
        arst_n   = 1'b0;
        ppu_rstn = 1'b1;
        ppu1_cs  = 1'b0;
        ppu2_cs  = 1'b0;
        addr     = '0;
        dsn      = 2'b11;
        cpu_dout = '0;
        gfx_en   = '0;
        add_exp  = 1'b0;
        rd_chk   = 1'b0;
        exp_x    = '0;
        exp_y    = '0;
        exp_rgb  = '0;
        rd_exp   = '0;
        vram_ok  = 1'b0;
        vram_data = '0;
        rom_ok   = 1'b0;
        rom_data = '0;
        load_stimulus(ok);
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        if (ok == 0) begin
            $display("Could not open the stimulus file sim/video_stimulus.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            run_commands();
            repeat (4) @(negedge clk);
            if (pix_checked != n_pix_exp) begin
                $display("Only %0d of %0d expected pixels were compared",
                         pix_checked, n_pix_exp);
                n_bad++;
            end
            total = pix_errs + rd_errs + raster_errs + n_bad;
            $display("Errors: pixel %0d, readback %0d, raster %0d, stimulus %0d",
                     pix_errs, rd_errs, raster_errs, n_bad);
            if (total == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Watchdog sized from the number of frame waits
    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(n_frames + 2) * V_TOTAL * H_TOTAL * 40;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/video_stimulus.txt ====
# W addr dsn data | P entry data | R addr expected | C pulses ppu_rstn | G gfx_en
# F waits for frame start | X x y rgb, all numbers in hex
G 1
W 0 2 AB12
W 0 1 34FF
R 0 3412
W 2 0 0015
R 2 0015
W 5 0 FFFF
R 5 0000
C
R 0 0000
R 1 0000
R 2 0000
R 3 0000
P 0 0123
P 5 05A0
P 1A 0F0F
P 14 0084
F
X 3 2 55AA00
X 9 1 FF00FF
X 0 0 112233
X D 7 008844
F
W 0 0 000B
W 1 0 0205
W 2 0 0015
P 12 09C3
P 1 00F0
X 2 0 99CC33
X 6 3 00FF00
X 14 E 99CC33
X 1E A 112233
F
W 3 0 0001
X 6 3 112233
X 2 0 112233
F
W 3 0 0000
G 0
X 6 3 112233
F
G 1
R 0 000B
R 1 0205
R 3 0000
X 6 3 00FF00
X 2 0 99CC33
F

// ==== sim.f ====
logic/video_pkg.sv
logic/video_timing.sv
logic/video_regs.sv
logic/scroll_layer.sv
logic/color_mix.sv
logic/video_core.sv
sim/video_checker.sv
sim/tb_video.sv

// ==== Makefile ====
# Verilator build and run for the tile video subsystem

VERILATOR ?= verilator
TOP       ?= tb_video
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard logic/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
